//--- src/dcache_pkg.sv
// data cache package with geometry, vector types, lsu functions and pipeline structs
package dcache_pkg;

    localparam int DATA_WIDTH        = 32;
    localparam int ADDR_WIDTH        = 32;
    localparam int LINE_SIZE         = 16;                   // bytes
    localparam int LINE_COUNT        = 16;
    localparam int WORD_SIZE         = DATA_WIDTH / 8;       // bytes
    localparam int LINE_WIDTH        = LINE_SIZE * 8;
    localparam int OFFSET_WIDTH      = $clog2(LINE_SIZE);
    localparam int INDEX_WIDTH       = $clog2(LINE_COUNT);
    localparam int TAG_WIDTH         = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int BYTE_OFFSET_WIDTH = $clog2(WORD_SIZE);    // byte within a word

    typedef logic [DATA_WIDTH-1:0]   word_t;
    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [TAG_WIDTH-1:0]    tag_t;
    typedef logic [INDEX_WIDTH-1:0]  index_t;
    typedef logic [OFFSET_WIDTH-1:0] offset_t;
    typedef logic [WORD_SIZE-1:0]    byte_sel_t;
    typedef logic [LINE_WIDTH-1:0]   line_t;

    typedef enum logic [2:0] {
        LSU_LB  = 3'd0,
        LSU_LH  = 3'd1,
        LSU_LW  = 3'd2,
        LSU_LBU = 3'd3,
        LSU_LHU = 3'd4,
        LSU_SB  = 3'd5,
        LSU_SH  = 3'd6,
        LSU_SW  = 3'd7
    } lsu_func_t;

    typedef struct packed {
        logic      valid;
        lsu_func_t func;
        addr_t     addr;
        word_t     data;
    } lsu_req_t;

    // valid marks a live entry, for a fill it is also the new line valid bit
    typedef struct packed {
        logic      wr_en;
        tag_t      tag;
        index_t    index;
        offset_t   offset;
        lsu_func_t func;
        word_t     data;
        logic      valid;
        logic      dirty;
        logic      fill;
        line_t     fill_data;
    } d0_in_t;

    typedef struct packed {
        d0_in_t    req;
        byte_sel_t byte_sel;
    } d1_in_t;

    typedef struct packed {
        logic  valid;
        logic  hit;
        logic  store;
        word_t data;
    } lsu_rsp_t;

    typedef struct packed {
        logic   valid;
        tag_t   tag;
        index_t index;
        logic   victim_dirty;
        tag_t   victim_tag;
        line_t  victim_line;
    } miss_t;

endpackage

//--- src/dcache_arb.sv
// data cache arbiter, picks a line fill or an lsu request for the pipeline
`timescale 1ns/1ns

module dcache_arb (
    input  dcache_pkg::lsu_req_t i_req,
    input  logic                 i_fill_valid,
    input  dcache_pkg::tag_t     i_fill_tag,
    input  dcache_pkg::index_t   i_fill_index,
    input  dcache_pkg::line_t    i_fill_line,
    input  logic                 i_fill_busy,
    output logic                 o_ready,
    output logic                 o_fill_taken,
    output dcache_pkg::d0_in_t   o_d0
);
    import dcache_pkg::*;

    logic is_store;

    assign is_store     = i_req.func inside {LSU_SB, LSU_SH, LSU_SW};
    assign o_ready      = ~i_fill_busy & ~i_fill_valid;   // fill always wins
    assign o_fill_taken = i_fill_valid;

    always_comb begin
        o_d0 = '0;
        if (i_fill_valid) begin
            o_d0.wr_en     = 1'b1;
            o_d0.tag       = i_fill_tag;
            o_d0.index     = i_fill_index;
            o_d0.func      = LSU_LW;
            o_d0.valid     = 1'b1;
            o_d0.dirty     = 1'b0;  // fresh line from memory
            o_d0.fill      = 1'b1;
            o_d0.fill_data = i_fill_line;
        end else begin
            o_d0.valid  = i_req.valid & o_ready;
            o_d0.wr_en  = i_req.valid & o_ready & is_store;
            o_d0.tag    = i_req.addr[ADDR_WIDTH-1 -: TAG_WIDTH];
            o_d0.index  = i_req.addr[OFFSET_WIDTH +: INDEX_WIDTH];
            o_d0.offset = i_req.addr[OFFSET_WIDTH-1:0];
            o_d0.func   = i_req.func;
            o_d0.data   = i_req.data;
        end
    end

    // the lsu must never see its request granted while a fill is offered
    always_comb begin
        assert #0 (!(i_fill_valid && i_req.valid && o_ready))
            else $error("lsu request granted while a fill is offered");
    end

endmodule

//--- src/dcache_d0.sv
// data cache stage 0, registers the request and decodes the byte select
`timescale 1ns/1ns

module dcache_d0 (
    input  logic               clk,
    input  logic               n_rst,
    input  dcache_pkg::d0_in_t i_d0,
    output dcache_pkg::d1_in_t o_d1
);
    import dcache_pkg::*;

    byte_sel_t byte_sel;

    always_comb begin
        case (i_d0.func)
            LSU_LB, LSU_LBU, LSU_SB: byte_sel = {{(WORD_SIZE-1){1'b0}}, 1'b1};
            LSU_LH, LSU_LHU, LSU_SH: byte_sel = {{(WORD_SIZE/2){1'b0}}, {(WORD_SIZE/2){1'b1}}};
            default:                 byte_sel = {WORD_SIZE{1'b1}};    // word access and fills
        endcase
    end

    // payload
    always_ff @(posedge clk) begin
        o_d1.req.tag       <= i_d0.tag;
        o_d1.req.index     <= i_d0.index;
        o_d1.req.offset    <= i_d0.offset;
        o_d1.req.func      <= i_d0.func;
        o_d1.req.data      <= i_d0.data;
        o_d1.req.dirty     <= i_d0.dirty;
        o_d1.req.fill      <= i_d0.fill;
        o_d1.req.fill_data <= i_d0.fill_data;
        o_d1.byte_sel      <= byte_sel;
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_d1.req.wr_en <= 1'b0;
            o_d1.req.valid <= 1'b0;
        end else begin
            o_d1.req.wr_en <= i_d0.wr_en;
            o_d1.req.valid <= i_d0.valid;
        end
    end

endmodule

//--- src/dcache_d1.sv
// data cache stage 1, tag and data arrays with hit check, store merge and load extract
`timescale 1ns/1ns

module dcache_d1 (
    input  logic                 clk,
    input  logic                 n_rst,
    input  dcache_pkg::d1_in_t   i_d1,
    input  logic                 i_fill_busy,
    output dcache_pkg::lsu_rsp_t o_rsp,
    output dcache_pkg::miss_t    o_miss
);
    import dcache_pkg::*;

    tag_t                  tag_ram  [LINE_COUNT];
    line_t                 data_ram [LINE_COUNT];
    logic [LINE_COUNT-1:0] line_valid;
    logic [LINE_COUNT-1:0] line_dirty;

    d0_in_t                       req;
    index_t                       idx;
    logic [OFFSET_WIDTH-BYTE_OFFSET_WIDTH-1:0] word_idx;
    logic [BYTE_OFFSET_WIDTH-1:0] byte_idx;
    line_t                        cur_line;
    line_t                        merged_line;
    byte_sel_t                    store_sel;
    word_t                        store_data;
    word_t                        load_word;
    word_t                        load_shift;
    word_t                        load_data;
    logic                         lsu_req;
    logic                         blocked;
    logic                         tag_hit;
    logic                         hit;
    logic                         miss;
    logic                         fill_wr;
    logic                         store_wr;

    assign req      = i_d1.req;
    assign idx      = req.index;
    assign word_idx = req.offset[OFFSET_WIDTH-1:BYTE_OFFSET_WIDTH];
    assign byte_idx = req.offset[BYTE_OFFSET_WIDTH-1:0];
    assign cur_line = data_ram[idx];

    // the miss just reported is not seen as busy by the fill unit yet
    assign blocked  = i_fill_busy | o_miss.valid;
    assign lsu_req  = req.valid & ~req.fill;
    assign tag_hit  = line_valid[idx] & (tag_ram[idx] == req.tag);
    assign hit      = lsu_req & tag_hit & ~blocked;
    assign miss     = lsu_req & ~tag_hit & ~blocked;
    assign fill_wr  = req.valid & req.fill & req.wr_en;
    assign store_wr = hit & req.wr_en;

    assign store_sel  = i_d1.byte_sel << byte_idx;
    assign store_data = req.data << (8 * byte_idx);

    always_comb begin
        merged_line = cur_line;
        for (int b = 0; b < WORD_SIZE; b++) begin
            if (store_sel[b])
                merged_line[word_idx*DATA_WIDTH + b*8 +: 8] = store_data[b*8 +: 8];
        end
    end

    assign load_word  = cur_line[word_idx*DATA_WIDTH +: DATA_WIDTH];
    assign load_shift = load_word >> (8 * byte_idx);

    always_comb begin
        case (req.func)
            LSU_LB:  load_data = {{24{load_shift[7]}}, load_shift[7:0]};
            LSU_LBU: load_data = {24'b0, load_shift[7:0]};
            LSU_LH:  load_data = {{16{load_shift[15]}}, load_shift[15:0]};
            LSU_LHU: load_data = {16'b0, load_shift[15:0]};
            default: load_data = load_shift;
        endcase
    end

    always_ff @(posedge clk) begin
        if (fill_wr) begin
            tag_ram[idx]  <= req.tag;
            data_ram[idx] <= req.fill_data;
        end else if (store_wr) begin
            data_ram[idx] <= merged_line;
        end

        o_rsp.hit          <= hit;
        o_rsp.store        <= req.wr_en;
        o_rsp.data         <= load_data;
        o_miss.tag         <= req.tag;
        o_miss.index       <= idx;
        o_miss.victim_dirty <= line_valid[idx] & line_dirty[idx];
        o_miss.victim_tag  <= tag_ram[idx];
        o_miss.victim_line <= cur_line;
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            line_valid   <= '0;
            line_dirty   <= '0;
            o_rsp.valid  <= 1'b0;
            o_miss.valid <= 1'b0;
        end else begin
            if (fill_wr) begin
                line_valid[idx] <= req.valid;
                line_dirty[idx] <= req.dirty;
            end else if (store_wr) begin
                line_dirty[idx] <= 1'b1;
            end
            o_rsp.valid  <= lsu_req;
            o_miss.valid <= miss;
        end
    end

    // a fill in this stage was offered in the cycle before, while the fill unit was busy
    assert property (@(posedge clk) disable iff (!n_rst)
        (req.valid && req.fill) |-> $past(i_fill_busy))
        else $error("fill reached d1 without a pending miss");

    assert property (@(posedge clk) disable iff (!n_rst)
        o_miss.valid |-> !i_fill_busy)
        else $error("miss reported while the fill unit is busy");

    assert property (@(posedge clk) disable iff (!n_rst)
        o_rsp.valid |-> !(req.valid && req.fill))
        else $error("lsu response overlaps a line fill");

endmodule

//--- src/dcache_fill.sv
// data cache miss handler, writes back a dirty victim and fetches the missing line
`timescale 1ns/1ns

module dcache_fill (
    input  logic               clk,
    input  logic               n_rst,
    input  dcache_pkg::miss_t  i_miss,
    input  logic               i_fill_taken,
    output logic               o_busy,
    output logic               o_fill_valid,
    output dcache_pkg::tag_t   o_fill_tag,
    output dcache_pkg::index_t o_fill_index,
    output dcache_pkg::line_t  o_fill_line,
    output logic               o_mem_en,
    output logic               o_mem_we,
    output dcache_pkg::addr_t  o_mem_addr,
    output dcache_pkg::line_t  o_mem_wdata,
    input  logic               i_mem_ack,
    input  dcache_pkg::line_t  i_mem_rdata
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WRITEBACK,
        READ,
        FILL
    } fill_state_t;

    fill_state_t state;
    tag_t        miss_tag;
    index_t      miss_index;
    tag_t        victim_tag;
    line_t       victim_line;
    line_t       line_q;

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (i_miss.valid) state <= i_miss.victim_dirty ? WRITEBACK : READ;
                WRITEBACK: if (i_mem_ack) state <= READ;
                READ:      if (i_mem_ack) state <= FILL;
                FILL:      if (i_fill_taken) state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && i_miss.valid) begin
            miss_tag    <= i_miss.tag;
            miss_index  <= i_miss.index;
            victim_tag  <= i_miss.victim_tag;
            victim_line <= i_miss.victim_line;
        end
        if (state == READ && i_mem_ack)
            line_q <= i_mem_rdata;
    end

    assign o_busy       = (state != IDLE);
    assign o_fill_valid = (state == FILL);
    assign o_fill_tag   = miss_tag;
    assign o_fill_index = miss_index;
    assign o_fill_line  = line_q;

    // held steady until the ack
    assign o_mem_en    = (state == WRITEBACK) || (state == READ);
    assign o_mem_we    = (state == WRITEBACK);
    assign o_mem_addr  = (state == WRITEBACK) ? {victim_tag, miss_index, {OFFSET_WIDTH{1'b0}}}
                                              : {miss_tag, miss_index, {OFFSET_WIDTH{1'b0}}};
    assign o_mem_wdata = victim_line;

    assert property (@(posedge clk) disable iff (!n_rst) i_mem_ack |-> o_mem_en)
        else $error("memory ack without an open request");

endmodule

//--- src/dcache.sv
// data cache top level, arbiter and two pipeline stages plus the miss handler
`timescale 1ns/1ns

module dcache (
    input  logic                 clk,
    input  logic                 n_rst,
    input  dcache_pkg::lsu_req_t i_req,
    output logic                 o_ready,
    output dcache_pkg::lsu_rsp_t o_rsp,
    output logic                 o_mem_en,
    output logic                 o_mem_we,
    output dcache_pkg::addr_t    o_mem_addr,
    output dcache_pkg::line_t    o_mem_wdata,
    input  logic                 i_mem_ack,
    input  dcache_pkg::line_t    i_mem_rdata
);
    import dcache_pkg::*;

    d0_in_t d0_in;
    d1_in_t d1_in;
    miss_t  miss;
    logic   fill_valid;
    logic   fill_taken;
    logic   fill_busy;
    tag_t   fill_tag;
    index_t fill_index;
    line_t  fill_line;

    dcache_arb arb (
        .i_req        (i_req),
        .i_fill_valid (fill_valid),
        .i_fill_tag   (fill_tag),
        .i_fill_index (fill_index),
        .i_fill_line  (fill_line),
        .i_fill_busy  (fill_busy),
        .o_ready      (o_ready),
        .o_fill_taken (fill_taken),
        .o_d0         (d0_in)
    );

    dcache_d0 d0 (.clk(clk), .n_rst(n_rst), .i_d0(d0_in), .o_d1(d1_in));

    dcache_d1 d1 (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_d1        (d1_in),
        .i_fill_busy (fill_busy),
        .o_rsp       (o_rsp),
        .o_miss      (miss)
    );

    dcache_fill fill (
        .clk          (clk),
        .n_rst        (n_rst),
        .i_miss       (miss),
        .i_fill_taken (fill_taken),
        .o_busy       (fill_busy),
        .o_fill_valid (fill_valid),
        .o_fill_tag   (fill_tag),
        .o_fill_index (fill_index),
        .o_fill_line  (fill_line),
        .o_mem_en     (o_mem_en),
        .o_mem_we     (o_mem_we),
        .o_mem_addr   (o_mem_addr),
        .o_mem_wdata  (o_mem_wdata),
        .i_mem_ack    (i_mem_ack),
        .i_mem_rdata  (i_mem_rdata)
    );

endmodule

//--- test/dcache_tb.sv
// data cache testbench, directed and random accesses against a memory model and byte reference
`timescale 1ns/1ns

module dcache_tb;
    import dcache_pkg::*;

    localparam int TIMEOUT      = 100;
    localparam int RANDOM_COUNT = 300;
    localparam int MEM_BYTES    = 4096;
    localparam int BURST_MAX    = 3;

    logic     clk;
    logic     n_rst;
    lsu_req_t i_req;
    logic     o_ready;
    lsu_rsp_t o_rsp;
    logic     o_mem_en;
    logic     o_mem_we;
    addr_t    o_mem_addr;
    line_t    o_mem_wdata;
    logic     i_mem_ack;
    line_t    i_mem_rdata;

    logic [7:0] mem_bytes [MEM_BYTES];    // backing memory
    logic [7:0] ref_bytes [MEM_BYTES];    // what the lsu should read back
    logic       model_valid [LINE_COUNT];
    logic       model_dirty [LINE_COUNT];
    tag_t       model_tag   [LINE_COUNT];

    lsu_rsp_t rsp_q [$];
    int       rsp_cycle_q [$];
    int       cycle = 0;

    // accesses of the current burst
    lsu_func_t q_func [BURST_MAX];
    addr_t     q_addr [BURST_MAX];
    word_t     q_data [BURST_MAX];
    int        q_exp  [BURST_MAX];    // -1 when the hit is left to the model
    logic      q_done [BURST_MAX];
    addr_t     allow_line [BURST_MAX];
    int        allow_count = 0;

    dcache dut (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_req       (i_req),
        .o_ready     (o_ready),
        .o_rsp       (o_rsp),
        .o_mem_en    (o_mem_en),
        .o_mem_we    (o_mem_we),
        .o_mem_addr  (o_mem_addr),
        .o_mem_wdata (o_mem_wdata),
        .i_mem_ack   (i_mem_ack),
        .i_mem_rdata (i_mem_rdata)
    );

    always #4 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // responses are collected mid cycle where they are stable
    always @(negedge clk) begin
        if (n_rst === 1'b1 && o_rsp.valid === 1'b1) begin
            rsp_q.push_back(o_rsp);
            rsp_cycle_q.push_back(cycle);
        end
    end

    always begin
        @(posedge clk);
        #1;
        serve_memory();
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            report_error($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_error($sformatf("Mismatch at %0t: %s expected %b got %b", $time, name, exp, act));
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp)
            report_error($sformatf("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act));
    endtask

    // low address byte xor a5, folded with the upper bits so aliasing lines differ
    function automatic logic [7:0] fill_pattern(input logic [11:0] a);
        return a[7:0] ^ {4'h0, a[11:8]} ^ 8'ha5;
    endfunction

    function automatic logic is_store(input lsu_func_t f);
        return (f == LSU_SB) || (f == LSU_SH) || (f == LSU_SW);
    endfunction

    function automatic word_t ref_word(input logic [11:0] a);
        return {ref_bytes[a+3], ref_bytes[a+2], ref_bytes[a+1], ref_bytes[a]};
    endfunction

    function automatic word_t expected_load(input lsu_func_t f, input addr_t a);
        logic [11:0] p;
        logic [7:0]  b;
        logic [15:0] h;
        p = a[11:0];
        b = ref_bytes[p];
        h = {ref_bytes[p+1], ref_bytes[p]};
        case (f)
            LSU_LB:  return {{24{b[7]}}, b};
            LSU_LBU: return {24'h0, b};
            LSU_LH:  return {{16{h[15]}}, h};
            LSU_LHU: return {16'h0, h};
            default: return ref_word(p);
        endcase
    endfunction

    task automatic apply_store(input lsu_func_t f, input addr_t a, input word_t d);
        logic [11:0] p;
        p = a[11:0];
        ref_bytes[p] = d[7:0];
        if (f != LSU_SB)
            ref_bytes[p+1] = d[15:8];
        if (f == LSU_SW) begin
            ref_bytes[p+2] = d[23:16];
            ref_bytes[p+3] = d[31:24];
        end
    endtask

    // one transfer per call, ack after 1 to 4 cycles
    task automatic serve_memory();
        int          lat;
        int          k;
        index_t      idx;
        logic [11:0] base;
        addr_t       exp_addr;
        line_t       line;
        i_mem_ack = 1'b0;
        if (n_rst === 1'b1 && o_mem_en === 1'b1) begin
            check_bit("o_ready", 1'b0, o_ready);
            lat = $urandom_range(4, 1);
            repeat (lat) @(posedge clk);
            #1;
            idx  = o_mem_addr[7:4];
            base = o_mem_addr[11:0];
            if (o_mem_we) begin
                if (!(model_valid[idx] && model_dirty[idx]))
                    report_error("memory write for a line that is not dirty in the cache");
                check_addr("o_mem_addr", {model_tag[idx], idx, 4'h0}, o_mem_addr);
                for (k = 0; k < LINE_SIZE / WORD_SIZE; k++)
                    check_word("o_mem_wdata", ref_word(base + 4 * k), o_mem_wdata[k*32 +: 32]);
                for (k = 0; k < LINE_SIZE; k++)
                    mem_bytes[base + k] = o_mem_wdata[k*8 +: 8];
                model_dirty[idx] = 1'b0;
            end else begin
                exp_addr = allow_line[0];
                for (k = 0; k < allow_count; k++) begin
                    if (o_mem_addr == allow_line[k])
                        exp_addr = allow_line[k];
                end
                check_addr("o_mem_addr", exp_addr, o_mem_addr);
                if (model_valid[idx] && model_dirty[idx])
                    report_error("dirty victim was not written back before the line read");
                for (k = 0; k < LINE_SIZE; k++)
                    line[k*8 +: 8] = mem_bytes[base + k];
                i_mem_rdata      = line;
                model_valid[idx] = 1'b1;
                model_dirty[idx] = 1'b0;
                model_tag[idx]   = o_mem_addr[31:8];
            end
            i_mem_ack = 1'b1;
        end
    endtask

    task automatic load_entry(input int k, input lsu_func_t f, input addr_t a, input word_t d,
                              input int exp);
        q_func[k] = f;
        q_addr[k] = a;
        q_data[k] = d;
        q_exp[k]  = exp;
        q_done[k] = 1'b0;
    endtask

    task automatic load_random(input int k);
        lsu_func_t f;
        addr_t     a;
        f = lsu_func_t'($urandom_range(7, 0));
        a = $urandom_range(1023, 0);    // 1 KB window, four tags per index
        if (f == LSU_LH || f == LSU_LHU || f == LSU_SH)
            a[0] = 1'b0;
        else if (f == LSU_LW || f == LSU_SW)
            a[1:0] = 2'b00;
        load_entry(k, f, a, $urandom, -1);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (o_ready !== 1'b1) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT)
                report_error("o_ready stayed low for 100 cycles");
        end
    endtask

    task automatic wait_rsp(output lsu_rsp_t r, output int c);
        int n;
        n = 0;
        while (rsp_q.size() == 0) begin
            @(posedge clk);
            #1;
            n++;
            if (n > TIMEOUT)
                report_error("no response pulse within 100 cycles of a request");
        end
        r = rsp_q.pop_front();
        c = rsp_cycle_q.pop_front();
    endtask

    task automatic check_rsp(input int i, input lsu_rsp_t r);
        index_t idx;
        idx = q_addr[i][7:4];
        check_bit("o_rsp.store", is_store(q_func[i]), r.store);
        if (q_exp[i] >= 0)
            check_bit("o_rsp.hit", q_exp[i] == 1, r.hit);
        q_exp[i] = -1;    // a replay is predicted again from the model
        if (r.hit) begin
            if (!model_valid[idx] || model_tag[idx] != q_addr[i][31:8])
                report_error("hit reported for a line that was never fetched");
            if (is_store(q_func[i])) begin
                apply_store(q_func[i], q_addr[i], q_data[i]);
                model_dirty[idx] = 1'b1;
            end else begin
                check_word("o_rsp.data", expected_load(q_func[i], q_addr[i]), r.data);
            end
            q_done[i] = 1'b1;
        end
    endtask

    // entries first .. first+n-1 go in on consecutive cycles
    task automatic issue_burst(input int first, input int n);
        int       take [BURST_MAX];
        lsu_rsp_t r;
        int       c;
        int       k;
        logic     blocked;
        index_t   idx;
        wait_ready();
        allow_count = n;
        for (k = 0; k < n; k++)
            allow_line[k] = {q_addr[first+k][31:4], 4'h0};
        blocked = 1'b0;
        for (k = 0; k < n; k++) begin
            idx = q_addr[first+k][7:4];
            if (q_exp[first+k] < 0)
                q_exp[first+k] = (!blocked && model_valid[idx] &&
                                  model_tag[idx] == q_addr[first+k][31:8]) ? 1 : 0;
            if (q_exp[first+k] == 0)
                blocked = 1'b1;    // everything behind a miss is turned away
        end
        for (k = 0; k < n; k++) begin
            check_bit("o_ready", 1'b1, o_ready);
            i_req.valid = 1'b1;
            i_req.func  = q_func[first+k];
            i_req.addr  = q_addr[first+k];
            i_req.data  = q_data[first+k];
            @(posedge clk);
            #1;
            take[k] = cycle;
        end
        i_req.valid = 1'b0;
        for (k = 0; k < n; k++) begin
            wait_rsp(r, c);
            if (c != take[k] + 1)
                report_error($sformatf("Mismatch at %0t: o_rsp.valid cycle expected %0d got %0d",
                                       $time, take[k] + 1, c));
            check_rsp(first + k, r);
        end
    endtask

    task automatic complete_all(input int n);
        int k;
        int tries;
        for (k = 0; k < n; k++) begin
            tries = 0;
            while (!q_done[k]) begin
                tries++;
                if (tries > TIMEOUT)
                    report_error("access still missing after 100 replays");
                issue_burst(k, 1);
            end
        end
    endtask

    task automatic run_single(input lsu_func_t f, input addr_t a, input word_t d, input int exp);
        load_entry(0, f, a, d, exp);
        issue_burst(0, 1);
        complete_all(1);
    endtask

    initial begin : main_seq
        int            fd;
        int            fnum;
        addr_t         a;
        word_t         d;
        logic [1023:0] text;
        int            issued;
        int            n;
        int            k;
        clk         = 1'b0;
        n_rst       = 1'b0;
        i_req       = '0;
        i_mem_ack   = 1'b0;
        i_mem_rdata = '0;
        void'($urandom(29));
        for (k = 0; k < MEM_BYTES; k++) begin
            mem_bytes[k] = fill_pattern(k[11:0]);
            ref_bytes[k] = mem_bytes[k];
        end
        for (k = 0; k < LINE_COUNT; k++) begin
            model_valid[k] = 1'b0;
            model_dirty[k] = 1'b0;
            model_tag[k]   = '0;
        end

        repeat (4) @(posedge clk);
        #1;
        n_rst = 1'b1;
        check_bit("o_mem_en", 1'b0, o_mem_en);
        check_bit("o_rsp.valid", 1'b0, o_rsp.valid);
        check_bit("o_ready", 1'b1, o_ready);

        run_single(LSU_LW, 32'h0, 32'h0, 0);    // cold line must miss first

        fd = $fopen("test/dcache_tests.txt", "r");
        if (fd == 0)
            report_error("cannot open test/dcache_tests.txt");
        while ($fgets(text, fd) != 0) begin
            if ($sscanf(text, "%d %h %h", fnum, a, d) == 3)
                run_single(lsu_func_t'(fnum[2:0]), a, d, -1);
        end
        $fclose(fd);

        // back to back hits
        run_single(LSU_LW, 32'h40, 32'h0, -1);
        run_single(LSU_LW, 32'h80, 32'h0, -1);
        load_entry(0, LSU_LW, 32'h40, 32'h0, 1);
        load_entry(1, LSU_LH, 32'h46, 32'h0, 1);
        load_entry(2, LSU_LBU, 32'h4b, 32'h0, 1);
        issue_burst(0, 3);
        complete_all(3);

        // a cached line right behind a miss is blocked too
        load_entry(0, LSU_LW, 32'h140, 32'h0, 0);
        load_entry(1, LSU_LW, 32'h84, 32'h0, 0);
        issue_burst(0, 2);
        complete_all(2);

        issued = 0;
        while (issued < RANDOM_COUNT) begin
            n = $urandom_range(BURST_MAX, 1);
            for (k = 0; k < n; k++)
                load_random(k);
            issue_burst(0, n);
            complete_all(n);
            issued += n;
        end

        repeat (2) @(posedge clk);
        #1;
        if (rsp_q.size() != 0) begin
            report_error("response pulse without a matching request");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

//--- dcache.f
src/dcache_pkg.sv
src/dcache_arb.sv
src/dcache_d0.sv
src/dcache_d1.sv
src/dcache_fill.sv
src/dcache.sv
test/dcache_tb.sv

//--- test/dcache_tests.txt
# func (0 lb, 1 lh, 2 lw, 3 lbu, 4 lhu, 5 sb, 6 sh, 7 sw), address in hex, store data in hex
# one access per line, loads carry a zero data column
2 00000004 00000000
0 00000003 00000000
3 00000003 00000000
1 00000006 00000000
4 00000006 00000000
0 00000080 00000000
1 00000082 00000000
5 00000001 0000007f
6 0000000a 00008123
7 0000000c deadbeef
2 00000000 00000000
2 00000008 00000000
0 0000000f 00000000
1 0000000e 00000000
4 0000000e 00000000
3 0000000c 00000000
2 00000100 00000000
2 0000000c 00000000
7 00000214 12345678
2 00000314 00000000
2 00000214 00000000
